//--- Makefile
VERILATOR ?= verilator
TOP := dcache_tb
FILELIST := filelist.f
OBJ_DIR := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert
PASS_MSG := All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line appears in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/data_memory_checker.sv
`default_nettype none

// protocol checks on the block memory strobes
module data_memory_checker (
	input wire clock,
	input wire reset,
	input wire ren,
	input wire wen,
	input wire ready,
	input wire done
);

	timeunit 1ns;
	timeprecision 100ps;

	// read back by the testbench for its closing report
	int failure_count = 0;

	// the controller never raises read and write at once
	strobes_exclusive: assert property (@(posedge clock) disable iff (!reset)
		!(ren && wen))
	else
	begin
		$error("ren and wen are high in the same cycle");
		failure_count++;
	end

	// ready only follows a held read
	ready_after_ren: assert property (@(posedge clock) disable iff (!reset)
		ready |-> $past(ren))
	else
	begin
		$error("ready is high without ren on the previous edge");
		failure_count++;
	end

	// done only follows a held write
	done_after_wen: assert property (@(posedge clock) disable iff (!reset)
		done |-> $past(wen))
	else
	begin
		$error("done is high without wen on the previous edge");
		failure_count++;
	end

endmodule

bind data_memory data_memory_checker i_data_memory_checker (
	.clock(clock),
	.reset(reset),
	.ren(ren),
	.wen(wen),
	.ready(ready),
	.done(done)
);

`default_nettype wire

//--- bench/dcache_tb.sv
`default_nettype none

module dcache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic clock = 1'b0;
	logic reset;
	logic cpu_read;
	logic cpu_write;
	logic [dcache_pkg::ADDR_BITS-1:0] cpu_address;
	logic [dcache_pkg::WORD_BITS-1:0] cpu_write_data;
	logic [dcache_pkg::WORD_BITS-1:0] cpu_read_data;
	logic cpu_ack;

	// reference memory, one entry per word, filled from the block file
	logic [dcache_pkg::WORD_BITS-1:0] model_mem
		[dcache_pkg::DMEM_SIZE_BLOCKS * dcache_pkg::WORDS_PER_BLOCK];
	logic [dcache_pkg::DBLOCK_SIZE_BITS-1:0] init_blocks [dcache_pkg::DMEM_SIZE_BLOCKS];

	// expected load result, handed to the compare process
	logic [dcache_pkg::WORD_BITS-1:0] expected_word;
	string load_name;

	// word errors belong to the compare process, the rest to the stimulus
	int word_errors = 0;
	int flag_errors = 0;
	int timeout_count = 0;
	logic [31:0] rng_state;

	dcache_subsystem i_dcache_subsystem (
		.clock(clock),
		.reset(reset),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_address(cpu_address),
		.cpu_write_data(cpu_write_data),
		.cpu_read_data(cpu_read_data),
		.cpu_ack(cpu_ack)
	);

	// 8 ns clock
	always #4 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected word at a byte address, low two bits dropped
	function automatic logic [dcache_pkg::WORD_BITS-1:0] model_read(
		input logic [dcache_pkg::ADDR_BITS-1:0] address);
		return model_mem[address[dcache_pkg::ADDR_BITS-1:dcache_pkg::BYTE_OFFSET_BITS]];
	endfunction

	task automatic check_word(input string name,
		input logic [dcache_pkg::WORD_BITS-1:0] expected,
		input logic [dcache_pkg::WORD_BITS-1:0] actual);
		if (actual !== expected)
		begin
			word_errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			flag_errors++;
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// one processor request, held until the ack or the timeout
	task automatic access(input logic is_write,
		input logic [dcache_pkg::ADDR_BITS-1:0] address,
		input logic [dcache_pkg::WORD_BITS-1:0] data,
		input string name);
		int cycles;
		logic acked;
		@(posedge clock);
		#1;
		expected_word = model_read(address);
		load_name = name;
		cpu_address = address;
		cpu_write_data = data;
		cpu_read = !is_write;
		cpu_write = is_write;
		cycles = 0;
		acked = 1'b0;
		// ack is a one cycle pulse, so look for it mid cycle
		while (!acked && cycles < 200)
		begin
			@(negedge clock);
			if (cpu_ack)
			begin
				acked = 1'b1;
			end
			else
			begin
				cycles++;
			end
		end
		if (!acked)
		begin
			timeout_count++;
			$display("Request %s got no cpu_ack within 200 cycles", name);
		end
		else if (is_write)
		begin
			model_mem[address[dcache_pkg::ADDR_BITS-1:dcache_pkg::BYTE_OFFSET_BITS]] = data;
		end
		// drop the strobe on the edge after the ack, giving one idle cycle
		@(posedge clock);
		#1;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
	endtask

	// load data is valid throughout the ack cycle
	always @(negedge clock)
	begin
		if (cpu_ack && cpu_read)
		begin
			check_word(load_name, expected_word, cpu_read_data);
		end
	end

	initial
	begin
		logic [dcache_pkg::ADDR_BITS-1:0] address;
		logic is_write;
		reset = 1'b0;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		cpu_address = '0;
		cpu_write_data = '0;
		rng_state = 32'h012588ae;

		// unpack the block file into words, word 0 in the low bits
		$readmemh("dmem_init.hex", init_blocks);
		for (int b = 0; b < dcache_pkg::DMEM_SIZE_BLOCKS; b++)
		begin
			for (int w = 0; w < dcache_pkg::WORDS_PER_BLOCK; w++)
			begin
				model_mem[b * dcache_pkg::WORDS_PER_BLOCK + w] =
					init_blocks[b][w * dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS];
			end
		end

		repeat (10) @(posedge clock);
		#1;
		reset = 1'b1;

		// no request, no ack
		repeat (8)
		begin
			@(negedge clock);
			check_flag("reset_idle_ack", 1'b0, cpu_ack);
		end

		// cold miss, then a hit in the same block
		access(1'b0, 10'h124, '0, "cold_load");
		access(1'b0, 10'h128, '0, "hit_load");

		// store then reload, neighbours stay as loaded
		access(1'b1, 10'h0C8, 32'hCAFE_0001, "store_word");
		access(1'b0, 10'h0C8, '0, "store_readback");
		access(1'b0, 10'h0C0, '0, "neighbour_word0");
		access(1'b0, 10'h0C4, '0, "neighbour_word1");
		access(1'b0, 10'h0CC, '0, "neighbour_word3");

		// same index, other tag, forces writeback of the dirty line
		access(1'b1, 10'h2A4, 32'h5EED_F00D, "evict_store");
		access(1'b0, 10'h0A4, '0, "evict_conflict");
		access(1'b0, 10'h2A4, '0, "evict_reload");

		// random mix over the whole byte space
		for (int n = 0; n < 300; n++)
		begin
			rng_state = xorshift32(rng_state);
			address = rng_state[dcache_pkg::ADDR_BITS-1:0];
			is_write = rng_state[31];
			rng_state = xorshift32(rng_state);
			access(is_write, address, rng_state, $sformatf("random_%0d", n));
		end

		repeat (4) @(posedge clock);
		$display("word errors %0d, flag errors %0d, timeouts %0d, assertion failures %0d",
			word_errors, flag_errors, timeout_count,
			i_dcache_subsystem.i_data_memory.i_data_memory_checker.failure_count);
		if (word_errors == 0 && flag_errors == 0 && timeout_count == 0 &&
			i_dcache_subsystem.i_data_memory.i_data_memory_checker.failure_count == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/data_memory.sv
`default_nettype none

// slow block memory
// read: hold ren with a stable block_address, dout is valid while ready is high
// write: hold wen with block_address and din, the block is stored when done rises
// a back to back access needs one cycle with both strobes low in between
module data_memory (
	input wire clock,
	input wire reset,
	input wire ren,
	input wire wen,
	input wire [dcache_pkg::DMEM_BLOCK_ADDR_SIZE-1:0] block_address,
	input wire dcache_pkg::dblock_t din,
	output logic ready,
	output logic done,
	output dcache_pkg::dblock_t dout
);

	// storage, flat block view
	logic [dcache_pkg::DBLOCK_SIZE_BITS-1:0] mem_array [dcache_pkg::DMEM_SIZE_BLOCKS];

	// write data taken on the first wen edge
	logic [dcache_pkg::DBLOCK_SIZE_BITS-1:0] write_data;
	logic write_captured;

	logic [dcache_pkg::DMEM_DELAY_CNTR_SIZE-1:0] delay_count;
	logic delay_full;
	logic single_strobe;
	logic read_active;
	logic write_active;

	// exactly one strobe high, otherwise the access is idle or illegal
	assign single_strobe = ren ^ wen;
	assign delay_full = &delay_count;

	// delay expired for the strobe that is held
	assign read_active = delay_full && ren && !wen;
	assign write_active = delay_full && wen && !ren;

	// delay counter
	// clears on idle or on both strobes, then saturates at all ones
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			delay_count <= '0;
		end
		else if (!single_strobe)
		begin
			delay_count <= '0;
		end
		else if (!delay_full)
		begin
			delay_count <= delay_count + 1'b1;
		end
	end

	// ready and done are registered one edge after the counter saturates
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			ready <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			ready <= read_active;
			done <= write_active;
		end
	end

	// read path, zero outside a completed read
	always_comb
	begin
		dout.bits = read_active ? mem_array[block_address] : '0;
	end

	// capture flag, armed again once wen drops
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			write_captured <= 1'b0;
		end
		else if (!wen || ren)
		begin
			write_captured <= 1'b0;
		end
		else
		begin
			write_captured <= 1'b1;
		end
	end

	// take din only on the first edge of a write
	always_ff @(posedge clock)
	begin
		if (wen && !ren && !write_captured)
		begin
			write_data <= din.bits;
		end
	end

	// block is committed once, on the edge where done rises
	always_ff @(posedge clock)
	begin
		if (write_active && !done)
		begin
			mem_array[block_address] <= write_data;
		end
	end

	// contents shared with the testbench model
	initial
	begin
		$readmemh("dmem_init.hex", mem_array);
	end

endmodule

`default_nettype wire

//--- design/dcache_controller.sv
`default_nettype none

// direct mapped write back data cache
// one request at a time, cpu side held until the one cycle cpu_ack
module dcache_controller (
	input wire clock,
	input wire reset,
	input wire cpu_read,
	input wire cpu_write,
	input wire [dcache_pkg::ADDR_BITS-1:0] cpu_address,
	input wire [dcache_pkg::WORD_BITS-1:0] cpu_write_data,
	input wire mem_ready,
	input wire mem_done,
	input wire dcache_pkg::dblock_t mem_dout,
	output logic [dcache_pkg::WORD_BITS-1:0] cpu_read_data,
	output logic cpu_ack,
	output logic mem_ren,
	output logic mem_wen,
	output logic [dcache_pkg::DMEM_BLOCK_ADDR_SIZE-1:0] mem_block_address,
	output dcache_pkg::dblock_t mem_din
);

	// line storage
	dcache_pkg::dblock_t line_data [dcache_pkg::CACHE_LINES];
	logic [dcache_pkg::TAG_BITS-1:0] tag_array [dcache_pkg::CACHE_LINES];
	logic [dcache_pkg::CACHE_LINES-1:0] valid_bits;
	logic [dcache_pkg::CACHE_LINES-1:0] dirty_bits;

	logic [1:0] state;

	// fields of the held request address
	logic [dcache_pkg::TAG_BITS-1:0] req_tag;
	logic [dcache_pkg::INDEX_BITS-1:0] req_index;
	logic [dcache_pkg::OFFSET_BITS-1:0] req_offset;

	logic request;
	logic new_request;
	logic hit;
	logic hit_store;
	logic refill_fire;
	dcache_pkg::dblock_t refill_block;

	assign req_tag = cpu_address[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_BITS];
	assign req_index = cpu_address[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_BITS];
	assign req_offset = cpu_address[dcache_pkg::OFFSET_LSB +: dcache_pkg::OFFSET_BITS];

	assign request = cpu_read || cpu_write;
	// the request is still up during its own ack cycle, so skip it then
	assign new_request = (state == dcache_pkg::ST_IDLE) && request && !cpu_ack;

	assign hit = valid_bits[req_index] && (tag_array[req_index] == req_tag);
	assign hit_store = new_request && hit && cpu_write;
	// ready only counts while this controller is still holding ren
	assign refill_fire = (state == dcache_pkg::ST_REFILL) && mem_ren && mem_ready;

	// incoming block with the store word merged in for a store miss
	always_comb
	begin
		refill_block = mem_dout;
		if (cpu_write)
		begin
			refill_block.words[req_offset] = cpu_write_data;
		end
	end

	// load data straight from the line, valid in the ack cycle
	assign cpu_read_data = line_data[req_index].words[req_offset];

	// victim goes back to its own tag, a refill fetches the requested tag
	assign mem_block_address = (state == dcache_pkg::ST_WRITEBACK) ?
		{tag_array[req_index], req_index} : {req_tag, req_index};
	assign mem_din = line_data[req_index];

	// miss FSM and line status
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= dcache_pkg::ST_IDLE;
			cpu_ack <= 1'b0;
			mem_ren <= 1'b0;
			mem_wen <= 1'b0;
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else
		begin
			// ack is a single cycle pulse
			cpu_ack <= 1'b0;
			case (state)
				dcache_pkg::ST_IDLE:
				begin
					if (new_request)
					begin
						if (hit)
						begin
							cpu_ack <= 1'b1;
							if (cpu_write)
							begin
								dirty_bits[req_index] <= 1'b1;
							end
						end
						else if (valid_bits[req_index] && dirty_bits[req_index])
						begin
							// dirty victim must reach memory before the refill
							mem_wen <= 1'b1;
							state <= dcache_pkg::ST_WRITEBACK;
						end
						else
						begin
							mem_ren <= 1'b1;
							state <= dcache_pkg::ST_REFILL;
						end
					end
				end
				dcache_pkg::ST_WRITEBACK:
				begin
					if (mem_wen && mem_done)
					begin
						// wen drops here and ren rises one cycle later,
						// so the memory counter sees an idle cycle
						mem_wen <= 1'b0;
						dirty_bits[req_index] <= 1'b0;
						state <= dcache_pkg::ST_REFILL;
					end
				end
				dcache_pkg::ST_REFILL:
				begin
					if (refill_fire)
					begin
						mem_ren <= 1'b0;
						valid_bits[req_index] <= 1'b1;
						dirty_bits[req_index] <= cpu_write;
						cpu_ack <= 1'b1;
						state <= dcache_pkg::ST_IDLE;
					end
					else
					begin
						mem_ren <= 1'b1;
					end
				end
				default:
				begin
					state <= dcache_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// line payload and tags
	always_ff @(posedge clock)
	begin
		if (hit_store)
		begin
			line_data[req_index].words[req_offset] <= cpu_write_data;
		end
		if (refill_fire)
		begin
			line_data[req_index] <= refill_block;
			tag_array[req_index] <= req_tag;
		end
	end

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// processor word and block geometry
	localparam int WORD_BITS = 32;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int DBLOCK_SIZE_BITS = WORD_BITS * WORDS_PER_BLOCK;

	// backing data memory, 64 blocks of 128 bits
	localparam int DMEM_SIZE_BLOCKS = 64;
	localparam int DMEM_BLOCK_ADDR_SIZE = 6;
	// 2 bits gives a saturated counter after three counting edges
	localparam int DMEM_DELAY_CNTR_SIZE = 2;

	// processor byte address, split as tag | index | word offset | byte offset
	localparam int BYTE_OFFSET_BITS = 2;
	localparam int OFFSET_BITS = 2;
	localparam int INDEX_BITS = 3;
	localparam int TAG_BITS = 3;
	localparam int ADDR_BITS = TAG_BITS + INDEX_BITS + OFFSET_BITS + BYTE_OFFSET_BITS;

	// field positions inside the byte address
	localparam int OFFSET_LSB = BYTE_OFFSET_BITS;
	localparam int INDEX_LSB = OFFSET_LSB + OFFSET_BITS;
	localparam int TAG_LSB = INDEX_LSB + INDEX_BITS;

	// direct mapped, one line per index value
	localparam int CACHE_LINES = 2 ** INDEX_BITS;

	// cache controller state encoding
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WRITEBACK = 2'd1;
	localparam logic [1:0] ST_REFILL = 2'd2;

	// one memory block, seen either flat or as words
	// word 0 sits in the least significant 32 bits
	typedef union packed {
		logic [DBLOCK_SIZE_BITS-1:0] bits;
		logic [WORDS_PER_BLOCK-1:0][WORD_BITS-1:0] words;
	} dblock_t;

endpackage

`default_nettype wire

//--- design/dcache_subsystem.sv
`default_nettype none

// data cache in front of the slow block memory
module dcache_subsystem (
	input wire clock,
	input wire reset,
	input wire cpu_read,
	input wire cpu_write,
	input wire [dcache_pkg::ADDR_BITS-1:0] cpu_address,
	input wire [dcache_pkg::WORD_BITS-1:0] cpu_write_data,
	output logic [dcache_pkg::WORD_BITS-1:0] cpu_read_data,
	output logic cpu_ack
);

	// cache to memory block bus
	logic mem_ren;
	logic mem_wen;
	logic mem_ready;
	logic mem_done;
	logic [dcache_pkg::DMEM_BLOCK_ADDR_SIZE-1:0] mem_block_address;
	dcache_pkg::dblock_t mem_din;
	dcache_pkg::dblock_t mem_dout;

	dcache_controller i_dcache_controller (
		.clock(clock),
		.reset(reset),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_address(cpu_address),
		.cpu_write_data(cpu_write_data),
		.mem_ready(mem_ready),
		.mem_done(mem_done),
		.mem_dout(mem_dout),
		.cpu_read_data(cpu_read_data),
		.cpu_ack(cpu_ack),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_block_address(mem_block_address),
		.mem_din(mem_din)
	);

	data_memory i_data_memory (
		.clock(clock),
		.reset(reset),
		.ren(mem_ren),
		.wen(mem_wen),
		.block_address(mem_block_address),
		.din(mem_din),
		.ready(mem_ready),
		.done(mem_done),
		.dout(mem_dout)
	);

endmodule

`default_nettype wire

//--- dmem_init.hex
// one 128-bit block per line, word 3 leftmost down to word 0 rightmost
D0033CFCD0023CFDD0013CFED0003CFF
D0073CF8D0063CF9D0053CFAD0043CFB
D00B3CF4D00A3CF5D0093CF6D0083CF7
D00F3CF0D00E3CF1D00D3CF2D00C3CF3
D0133CECD0123CEDD0113CEED0103CEF
D0173CE8D0163CE9D0153CEAD0143CEB
D01B3CE4D01A3CE5D0193CE6D0183CE7
D01F3CE0D01E3CE1D01D3CE2D01C3CE3
D0233CDCD0223CDDD0213CDED0203CDF
D0273CD8D0263CD9D0253CDAD0243CDB
D02B3CD4D02A3CD5D0293CD6D0283CD7
D02F3CD0D02E3CD1D02D3CD2D02C3CD3
D0333CCCD0323CCDD0313CCED0303CCF
D0373CC8D0363CC9D0353CCAD0343CCB
D03B3CC4D03A3CC5D0393CC6D0383CC7
D03F3CC0D03E3CC1D03D3CC2D03C3CC3
D0433CBCD0423CBDD0413CBED0403CBF
D0473CB8D0463CB9D0453CBAD0443CBB
D04B3CB4D04A3CB5D0493CB6D0483CB7
D04F3CB0D04E3CB1D04D3CB2D04C3CB3
D0533CACD0523CADD0513CAED0503CAF
D0573CA8D0563CA9D0553CAAD0543CAB
D05B3CA4D05A3CA5D0593CA6D0583CA7
D05F3CA0D05E3CA1D05D3CA2D05C3CA3
D0633C9CD0623C9DD0613C9ED0603C9F
D0673C98D0663C99D0653C9AD0643C9B
D06B3C94D06A3C95D0693C96D0683C97
D06F3C90D06E3C91D06D3C92D06C3C93
D0733C8CD0723C8DD0713C8ED0703C8F
D0773C88D0763C89D0753C8AD0743C8B
D07B3C84D07A3C85D0793C86D0783C87
D07F3C80D07E3C81D07D3C82D07C3C83
D0833C7CD0823C7DD0813C7ED0803C7F
D0873C78D0863C79D0853C7AD0843C7B
D08B3C74D08A3C75D0893C76D0883C77
D08F3C70D08E3C71D08D3C72D08C3C73
D0933C6CD0923C6DD0913C6ED0903C6F
D0973C68D0963C69D0953C6AD0943C6B
D09B3C64D09A3C65D0993C66D0983C67
D09F3C60D09E3C61D09D3C62D09C3C63
D0A33C5CD0A23C5DD0A13C5ED0A03C5F
D0A73C58D0A63C59D0A53C5AD0A43C5B
D0AB3C54D0AA3C55D0A93C56D0A83C57
D0AF3C50D0AE3C51D0AD3C52D0AC3C53
D0B33C4CD0B23C4DD0B13C4ED0B03C4F
D0B73C48D0B63C49D0B53C4AD0B43C4B
D0BB3C44D0BA3C45D0B93C46D0B83C47
D0BF3C40D0BE3C41D0BD3C42D0BC3C43
D0C33C3CD0C23C3DD0C13C3ED0C03C3F
D0C73C38D0C63C39D0C53C3AD0C43C3B
D0CB3C34D0CA3C35D0C93C36D0C83C37
D0CF3C30D0CE3C31D0CD3C32D0CC3C33
D0D33C2CD0D23C2DD0D13C2ED0D03C2F
D0D73C28D0D63C29D0D53C2AD0D43C2B
D0DB3C24D0DA3C25D0D93C26D0D83C27
D0DF3C20D0DE3C21D0DD3C22D0DC3C23
D0E33C1CD0E23C1DD0E13C1ED0E03C1F
D0E73C18D0E63C19D0E53C1AD0E43C1B
D0EB3C14D0EA3C15D0E93C16D0E83C17
D0EF3C10D0EE3C11D0ED3C12D0EC3C13
D0F33C0CD0F23C0DD0F13C0ED0F03C0F
D0F73C08D0F63C09D0F53C0AD0F43C0B
D0FB3C04D0FA3C05D0F93C06D0F83C07
D0FF3C00D0FE3C01D0FD3C02D0FC3C03

//--- filelist.f
design/dcache_pkg.sv
design/data_memory.sv
design/dcache_controller.sv
design/dcache_subsystem.sv
bench/data_memory_checker.sv
bench/dcache_tb.sv
